/* common/alioth_pkg.sv */
/* shared widths, register index type and operation encoding for the execute cluster
   only three operations exist, the remaining enum code is unused */
`default_nettype none

package alioth_pkg;

    // data path width, multiply latency follows it
    localparam int XLEN = 32;

    // architectural registers, x0 reads zero
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;

    typedef logic [4:0] reg_addr_t;

    // issue opcodes
    typedef enum logic [1:0] {
        OP_ADDI  = 2'd0,
        OP_MUL   = 2'd1,
        OP_MULHU = 2'd2
    } op_e;

endpackage

`default_nettype wire

/* logic/regfile.sv */
/* register file with two operand reads, one debug read and one write port
   all entries clear on reset, writes to x0 are dropped */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        we_i,
    input  wire alioth_pkg::reg_addr_t waddr_i,
    input  wire alioth_pkg::word_t     wdata_i,
    input  wire alioth_pkg::reg_addr_t raddr1_i,
    input  wire alioth_pkg::reg_addr_t raddr2_i,
    input  wire alioth_pkg::reg_addr_t dbg_raddr_i,
    output alioth_pkg::word_t          rdata1_o,
    output alioth_pkg::word_t          rdata2_o,
    output alioth_pkg::word_t          dbg_rdata_o
);
    import alioth_pkg::*;

    word_t regs_q [NUM_REGS];

    // x0 stays at its reset value
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // reads see the old value in the cycle of a write
    assign rdata1_o    = regs_q[raddr1_i];
    assign rdata2_o    = regs_q[raddr2_i];
    assign dbg_rdata_o = regs_q[dbg_raddr_i];

endmodule

`default_nettype wire

/* issue/issue_unit.sv */
/* decode, destination scoreboard and stall for one presented instruction
   the source must hold the instruction while stall_o is high */
`timescale 1ns/1ps
`default_nettype none

module issue_unit #(
    parameter int NUM_MUL_UNITS = 2
) (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        issue_valid_i,
    input  wire alioth_pkg::op_e       issue_op_i,
    input  wire alioth_pkg::reg_addr_t issue_rd_i,
    input  wire alioth_pkg::reg_addr_t issue_rs1_i,
    input  wire alioth_pkg::reg_addr_t issue_rs2_i,
    input  wire alioth_pkg::word_t     issue_imm_i,
    input  wire alioth_pkg::word_t     rs1_data_i,
    input  wire alioth_pkg::word_t     rs2_data_i,
    input  wire [NUM_MUL_UNITS-1:0]    unit_busy_i,
    input  wire                        commit_valid_i,
    input  wire alioth_pkg::reg_addr_t commit_rd_i,
    output alioth_pkg::reg_addr_t      rs1_addr_o,
    output alioth_pkg::reg_addr_t      rs2_addr_o,
    output logic                       stall_o,
    output logic                       busy_o,
    output logic [NUM_MUL_UNITS-1:0]   mul_start_o,
    output logic                       mul_high_o,
    output alioth_pkg::reg_addr_t      mul_rd_o,
    output alioth_pkg::word_t          mul_a_o,
    output alioth_pkg::word_t          mul_b_o,
    output logic                       alu_valid_o,
    output alioth_pkg::reg_addr_t      alu_rd_o,
    output alioth_pkg::word_t          alu_data_o
);
    import alioth_pkg::*;

    logic [NUM_REGS-1:0]      sb_q;
    logic [NUM_REGS-1:0]      sb_next;
    logic [NUM_MUL_UNITS-1:0] free_units;
    logic [NUM_MUL_UNITS-1:0] first_free;
    logic                     is_mul;
    logic                     hazard;
    logic                     accept;
    word_t                    rs1_val;
    word_t                    rs2_val;
    logic                     alu_valid_q;
    reg_addr_t                alu_rd_q;
    word_t                    alu_data_q;

    assign is_mul = (issue_op_i == OP_MUL) || (issue_op_i == OP_MULHU);

    // rs2 only matters for a multiply, rd covers write after write
    assign hazard = sb_q[issue_rs1_i] | (is_mul & sb_q[issue_rs2_i]) | sb_q[issue_rd_i];

    // lowest free unit as a one-hot vector
    assign free_units = ~unit_busy_i;
    assign first_free = free_units & (~free_units + 1'b1);

    assign stall_o = issue_valid_i & (hazard | (is_mul & ~(|free_units)));
    assign accept  = issue_valid_i & ~stall_o;

    assign rs1_addr_o = issue_rs1_i;
    assign rs2_addr_o = issue_rs2_i;

    // the ALU slot is written one edge late, so forward it
    assign rs1_val = (alu_valid_q && (alu_rd_q == issue_rs1_i) && (issue_rs1_i != '0))
                     ? alu_data_q : rs1_data_i;
    assign rs2_val = (alu_valid_q && (alu_rd_q == issue_rs2_i) && (issue_rs2_i != '0))
                     ? alu_data_q : rs2_data_i;

    assign mul_start_o = (accept && is_mul) ? first_free : '0;
    assign mul_high_o  = (issue_op_i == OP_MULHU);
    assign mul_rd_o    = issue_rd_i;
    assign mul_a_o     = rs1_val;
    assign mul_b_o     = rs2_val;

    always_comb begin
        sb_next = sb_q;
        if (commit_valid_i) begin
            sb_next[commit_rd_i] = 1'b0;
        end
        // x0 is never tracked
        if (accept && is_mul && (issue_rd_i != '0)) begin
            sb_next[issue_rd_i] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sb_q        <= '0;
            alu_valid_q <= 1'b0;
        end else begin
            sb_q        <= sb_next;
            alu_valid_q <= accept && (issue_op_i == OP_ADDI);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && (issue_op_i == OP_ADDI)) begin
            alu_rd_q   <= issue_rd_i;
            alu_data_q <= rs1_val + issue_imm_i;
        end
    end

    assign alu_valid_o = alu_valid_q;
    assign alu_rd_o    = alu_rd_q;
    assign alu_data_o  = alu_data_q;

    assign busy_o = alu_valid_q | (|unit_busy_i) | (|sb_q);

endmodule

`default_nettype wire

/* muldiv/muldiv_unit.sv */
/* iterative unsigned shift-add multiplier, XLEN cycles per product
   result and rd are held with done_o until ack_i, start_i is taken only when idle */
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        start_i,
    input  wire                        high_i,
    input  wire alioth_pkg::reg_addr_t rd_i,
    input  wire alioth_pkg::word_t     a_i,
    input  wire alioth_pkg::word_t     b_i,
    input  wire                        ack_i,
    output logic                       busy_o,
    output logic                       done_o,
    output alioth_pkg::reg_addr_t      rd_o,
    output alioth_pkg::word_t          result_o
);
    import alioth_pkg::*;

    localparam int CNT_W = $clog2(XLEN);

    logic [CNT_W-1:0]  count_q;
    logic              busy_q;
    logic              done_q;
    logic              high_q;
    reg_addr_t         rd_q;
    word_t             a_q;
    logic [2*XLEN-1:0] prod_q;
    logic [XLEN:0]     sum;

    // upper half plus multiplicand when the low multiplier bit is set
    assign sum = {1'b0, prod_q[2*XLEN-1:XLEN]} + (prod_q[0] ? {1'b0, a_q} : '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            count_q <= '0;
        end else if (start_i) begin
            busy_q  <= 1'b1;
            done_q  <= 1'b0;
            count_q <= '0;
        end else if (ack_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (busy_q && !done_q) begin
            count_q <= count_q + 1'b1;
            if (count_q == CNT_W'(XLEN - 1)) begin
                done_q <= 1'b1;
            end
        end
    end

    // low half starts as the multiplier and shifts out one bit per step
    always_ff @(posedge clk) begin
        if (start_i) begin
            a_q    <= a_i;
            rd_q   <= rd_i;
            high_q <= high_i;
            prod_q <= {{XLEN{1'b0}}, b_i};
        end else if (busy_q && !done_q) begin
            prod_q <= {sum, prod_q[XLEN-1:1]};
        end
    end

    assign busy_o   = busy_q;
    assign done_o   = done_q;
    assign rd_o     = rd_q;
    assign result_o = high_q ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];

endmodule

`default_nettype wire

/* logic/writeback_unit.sv */
/* one register write per cycle, ALU slot first, then the lowest done multiply unit
   the ack follows the write by one cycle, so a unit's done_o stays up for that cycle */
`timescale 1ns/1ps
`default_nettype none

module writeback_unit #(
    parameter int NUM_MUL_UNITS = 2
) (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        alu_valid_i,
    input  wire alioth_pkg::reg_addr_t alu_rd_i,
    input  wire alioth_pkg::word_t     alu_data_i,
    input  wire [NUM_MUL_UNITS-1:0]    unit_done_i,
    input  wire alioth_pkg::reg_addr_t unit_rd_i [NUM_MUL_UNITS],
    input  wire alioth_pkg::word_t     unit_result_i [NUM_MUL_UNITS],
    output logic [NUM_MUL_UNITS-1:0]   unit_ack_o,
    output logic                       reg_we_o,
    output alioth_pkg::reg_addr_t      reg_waddr_o,
    output alioth_pkg::word_t          reg_wdata_o,
    output logic                       commit_valid_o,
    output alioth_pkg::reg_addr_t      commit_rd_o
);
    import alioth_pkg::*;

    logic [NUM_MUL_UNITS-1:0] ack_q;
    logic [NUM_MUL_UNITS-1:0] pending;
    logic [NUM_MUL_UNITS-1:0] grant;

    // the unit written last cycle still shows done until its ack lands
    assign pending = unit_done_i & ~ack_q;

    always_comb begin
        reg_we_o       = 1'b0;
        reg_waddr_o    = '0;
        reg_wdata_o    = '0;
        commit_valid_o = 1'b0;
        commit_rd_o    = '0;
        grant          = '0;
        if (alu_valid_i) begin
            reg_we_o    = 1'b1;
            reg_waddr_o = alu_rd_i;
            reg_wdata_o = alu_data_i;
        end else begin
            // walk downwards so the lowest index wins
            for (int i = NUM_MUL_UNITS - 1; i >= 0; i--) begin
                if (pending[i]) begin
                    grant          = '0;
                    grant[i]       = 1'b1;
                    reg_we_o       = 1'b1;
                    reg_waddr_o    = unit_rd_i[i];
                    reg_wdata_o    = unit_result_i[i];
                    commit_valid_o = 1'b1;
                    commit_rd_o    = unit_rd_i[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= '0;
        end else begin
            ack_q <= grant;
        end
    end

    assign unit_ack_o = ack_q;

endmodule

`default_nettype wire

/* logic/exec_cluster_top.sv */
/* execute cluster: issue, NUM_MUL_UNITS multipliers, writeback and register file
   NUM_MUL_UNITS may be 1 to 4, instructions use a valid strobe held during stall_o */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_top #(
    parameter int NUM_MUL_UNITS = 2
) (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        issue_valid_i,
    input  wire alioth_pkg::op_e       issue_op_i,
    input  wire alioth_pkg::reg_addr_t issue_rd_i,
    input  wire alioth_pkg::reg_addr_t issue_rs1_i,
    input  wire alioth_pkg::reg_addr_t issue_rs2_i,
    input  wire alioth_pkg::word_t     issue_imm_i,
    input  wire alioth_pkg::reg_addr_t dbg_raddr_i,
    output logic                       stall_o,
    output logic                       busy_o,
    output alioth_pkg::word_t          dbg_rdata_o
);
    import alioth_pkg::*;

    // operand reads
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // issue to multipliers
    logic [NUM_MUL_UNITS-1:0] mul_start;
    logic                     mul_high;
    reg_addr_t                mul_rd;
    word_t                    mul_a;
    word_t                    mul_b;

    // multipliers to writeback
    logic [NUM_MUL_UNITS-1:0] unit_busy;
    logic [NUM_MUL_UNITS-1:0] unit_done;
    logic [NUM_MUL_UNITS-1:0] unit_ack;
    reg_addr_t                unit_rd [NUM_MUL_UNITS];
    word_t                    unit_result [NUM_MUL_UNITS];

    // ALU slot, register write port and commit report
    logic      alu_valid;
    reg_addr_t alu_rd;
    word_t     alu_data;
    logic      reg_we;
    reg_addr_t reg_waddr;
    word_t     reg_wdata;
    logic      commit_valid;
    reg_addr_t commit_rd;

    issue_unit #(
        .NUM_MUL_UNITS(NUM_MUL_UNITS)
    ) u_issue_unit (
        .clk           (clk),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .issue_rd_i    (issue_rd_i),
        .issue_rs1_i   (issue_rs1_i),
        .issue_rs2_i   (issue_rs2_i),
        .issue_imm_i   (issue_imm_i),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .unit_busy_i   (unit_busy),
        .commit_valid_i(commit_valid),
        .commit_rd_i   (commit_rd),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .stall_o       (stall_o),
        .busy_o        (busy_o),
        .mul_start_o   (mul_start),
        .mul_high_o    (mul_high),
        .mul_rd_o      (mul_rd),
        .mul_a_o       (mul_a),
        .mul_b_o       (mul_b),
        .alu_valid_o   (alu_valid),
        .alu_rd_o      (alu_rd),
        .alu_data_o    (alu_data)
    );

    // operands are broadcast, mul_start picks the unit
    for (genvar g = 0; g < NUM_MUL_UNITS; g++) begin : g_mul
        muldiv_unit u_muldiv_unit (
            .clk     (clk),
            .reset_i (reset_i),
            .start_i (mul_start[g]),
            .high_i  (mul_high),
            .rd_i    (mul_rd),
            .a_i     (mul_a),
            .b_i     (mul_b),
            .ack_i   (unit_ack[g]),
            .busy_o  (unit_busy[g]),
            .done_o  (unit_done[g]),
            .rd_o    (unit_rd[g]),
            .result_o(unit_result[g])
        );
    end

    writeback_unit #(
        .NUM_MUL_UNITS(NUM_MUL_UNITS)
    ) u_writeback_unit (
        .clk           (clk),
        .reset_i       (reset_i),
        .alu_valid_i   (alu_valid),
        .alu_rd_i      (alu_rd),
        .alu_data_i    (alu_data),
        .unit_done_i   (unit_done),
        .unit_rd_i     (unit_rd),
        .unit_result_i (unit_result),
        .unit_ack_o    (unit_ack),
        .reg_we_o      (reg_we),
        .reg_waddr_o   (reg_waddr),
        .reg_wdata_o   (reg_wdata),
        .commit_valid_o(commit_valid),
        .commit_rd_o   (commit_rd)
    );

    regfile u_regfile (
        .clk        (clk),
        .reset_i    (reset_i),
        .we_i       (reg_we),
        .waddr_i    (reg_waddr),
        .wdata_i    (reg_wdata),
        .raddr1_i   (rs1_addr),
        .raddr2_i   (rs2_addr),
        .dbg_raddr_i(dbg_raddr_i),
        .rdata1_o   (rs1_data),
        .rdata2_o   (rs2_data),
        .dbg_rdata_o(dbg_rdata_o)
    );

endmodule

`default_nettype wire

/* dv/tb_exec_cluster.sv */
/* testbench for the execute cluster built with two multiply units
   register contents are compared with an in-order model after each group drains */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;
    import alioth_pkg::*;

    localparam int NUM_MUL  = 2;
    localparam int MAX_ROWS = 32;
    localparam int LIMIT    = 400;

    logic      clk;
    logic      reset_i;
    logic      issue_valid_i;
    op_e       issue_op_i;
    reg_addr_t issue_rd_i;
    reg_addr_t issue_rs1_i;
    reg_addr_t issue_rs2_i;
    word_t     issue_imm_i;
    reg_addr_t dbg_raddr_i;
    logic      stall_o;
    logic      busy_o;
    word_t     dbg_rdata_o;

    // row_stall is -1 for any, 0 for no stall and 1 for at least one stall
    op_e       row_op    [MAX_ROWS];
    reg_addr_t row_rd    [MAX_ROWS];
    reg_addr_t row_rs1   [MAX_ROWS];
    reg_addr_t row_rs2   [MAX_ROWS];
    word_t     row_imm   [MAX_ROWS];
    logic      row_rnd   [MAX_ROWS];
    int        row_grp   [MAX_ROWS];
    int        row_stall [MAX_ROWS];
    int        n_rows;

    word_t       ref_regs [NUM_REGS];
    logic [31:0] lfsr_q;
    int          err_count;
    int          check_count;
    int          tests_run;
    int          test_fails;
    logic        timed_out;
    string       test_name [6] = '{"reset", "addi chain", "multiply values",
                                   "raw hazard", "parallel units", "waw hazard"};

    exec_cluster_top #(
        .NUM_MUL_UNITS(NUM_MUL)
    ) u_exec_cluster_top (
        .clk          (clk),
        .reset_i      (reset_i),
        .issue_valid_i(issue_valid_i),
        .issue_op_i   (issue_op_i),
        .issue_rd_i   (issue_rd_i),
        .issue_rs1_i  (issue_rs1_i),
        .issue_rs2_i  (issue_rs2_i),
        .issue_imm_i  (issue_imm_i),
        .dbg_raddr_i  (dbg_raddr_i),
        .stall_o      (stall_o),
        .busy_o       (busy_o),
        .dbg_rdata_o  (dbg_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output word_t val);
        val = '0;
        for (int b = 0; b < XLEN; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[XLEN-2:0], lfsr_q[0]};
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic add_row(input op_e op, input int rd, input int rs1, input int rs2,
                           input word_t imm, input logic rnd, input int grp, input int stall);
        row_op[n_rows]    = op;
        row_rd[n_rows]    = reg_addr_t'(rd);
        row_rs1[n_rows]   = reg_addr_t'(rs1);
        row_rs2[n_rows]   = reg_addr_t'(rs2);
        row_imm[n_rows]   = imm;
        row_rnd[n_rows]   = rnd;
        row_grp[n_rows]   = grp;
        row_stall[n_rows] = stall;
        n_rows++;
    endtask

    // entered and left just after a falling edge
    task automatic issue_row(input int i, output int stalls);
        int                guard;
        word_t             imm;
        word_t             val;
        logic [2*XLEN-1:0] prod;
        imm = row_imm[i];
        if (row_rnd[i]) begin
            rand_word(imm);
        end
        issue_valid_i = 1'b1;
        issue_op_i    = row_op[i];
        issue_rd_i    = row_rd[i];
        issue_rs1_i   = row_rs1[i];
        issue_rs2_i   = row_rs2[i];
        issue_imm_i   = imm;
        stalls = 0;
        guard  = 0;
        #1;
        while (stall_o && guard < LIMIT) begin
            stalls++;
            guard++;
            @(negedge clk);
            #1;
        end
        if (stall_o) begin
            timed_out = 1'b1;
            err_count++;
            $display("row %0d was still stalled after %0d cycles", i, LIMIT);
        end else begin
            // accepted at the next rising edge so the model updates in program order
            prod = {{XLEN{1'b0}}, ref_regs[row_rs1[i]]} * {{XLEN{1'b0}}, ref_regs[row_rs2[i]]};
            case (row_op[i])
                OP_MUL:   val = prod[XLEN-1:0];
                OP_MULHU: val = prod[2*XLEN-1:XLEN];
                default:  val = ref_regs[row_rs1[i]] + imm;
            endcase
            if (row_rd[i] != '0) begin
                ref_regs[row_rd[i]] = val;
            end
        end
        @(negedge clk);
        issue_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        int guard;
        guard = 0;
        while (busy_o && guard < LIMIT) begin
            guard++;
            @(negedge clk);
        end
        if (busy_o) begin
            timed_out = 1'b1;
            err_count++;
            $display("the cluster stayed busy for more than %0d cycles", LIMIT);
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < NUM_REGS; r++) begin
            dbg_raddr_i = reg_addr_t'(r);
            #1;
            check_word($sformatf("dbg_rdata_o x%0d", r), ref_regs[r], dbg_rdata_o);
            @(negedge clk);
        end
    endtask

    task automatic report_test(input int t, input int start);
        tests_run++;
        if (err_count != start) begin
            test_fails++;
            $display("test %0d %s: %0d errors", t, test_name[t], err_count - start);
        end else begin
            $display("test %0d %s: ok", t, test_name[t]);
        end
    endtask

    initial begin
        int stalls;
        int grp_start;
        reset_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_op_i    = OP_ADDI;
        issue_rd_i    = '0;
        issue_rs1_i   = '0;
        issue_rs2_i   = '0;
        issue_imm_i   = '0;
        dbg_raddr_i   = '0;
        lfsr_q        = 32'hb9d74237;
        err_count     = 0;
        check_count   = 0;
        tests_run     = 0;
        test_fails    = 0;
        timed_out     = 1'b0;
        n_rows        = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            ref_regs[r] = '0;
        end

        // addi chain that also writes x0
        add_row(OP_ADDI, 1, 0, 0, '0, 1'b1, 1, 0);
        add_row(OP_ADDI, 2, 1, 0, '0, 1'b1, 1, 0);
        add_row(OP_ADDI, 0, 2, 0, '0, 1'b1, 1, 0);
        add_row(OP_ADDI, 3, 2, 0, 32'hffff_ffff, 1'b0, 1, 0);
        add_row(OP_ADDI, 4, 0, 0, '0, 1'b1, 1, 0);
        add_row(OP_ADDI, 1, 1, 0, '0, 1'b1, 1, 0);
        // multiply values
        add_row(OP_ADDI, 5, 0, 0, '0, 1'b1, 2, -1);
        add_row(OP_ADDI, 6, 0, 0, '0, 1'b1, 2, -1);
        add_row(OP_MUL, 7, 5, 6, '0, 1'b0, 2, -1);
        add_row(OP_MULHU, 8, 5, 6, '0, 1'b0, 2, -1);
        add_row(OP_MULHU, 9, 3, 4, '0, 1'b0, 2, -1);
        add_row(OP_MUL, 10, 1, 5, '0, 1'b0, 2, -1);
        // consumers of a pending multiply
        add_row(OP_MUL, 11, 7, 8, '0, 1'b0, 3, -1);
        add_row(OP_ADDI, 12, 11, 0, '0, 1'b1, 3, 1);
        add_row(OP_MUL, 14, 5, 6, '0, 1'b0, 3, -1);
        add_row(OP_MULHU, 15, 14, 12, '0, 1'b0, 3, 1);
        // two units fill, the third multiply waits
        add_row(OP_MUL, 16, 5, 6, '0, 1'b0, 4, 0);
        add_row(OP_MULHU, 17, 7, 8, '0, 1'b0, 4, 0);
        add_row(OP_MUL, 18, 1, 2, '0, 1'b0, 4, 1);
        // write after write
        add_row(OP_MUL, 19, 5, 6, '0, 1'b0, 5, -1);
        add_row(OP_ADDI, 19, 3, 0, '0, 1'b1, 5, 1);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        grp_start = err_count;
        check_flag("busy_o", 1'b0, busy_o);
        check_regs();
        // a multiply to x0 sees a clear scoreboard and free units
        issue_valid_i = 1'b1;
        issue_op_i    = OP_MUL;
        issue_rd_i    = reg_addr_t'(0);
        issue_rs1_i   = reg_addr_t'(1);
        issue_rs2_i   = reg_addr_t'(2);
        #1;
        check_flag("stall_o", 1'b0, stall_o);
        @(negedge clk);
        issue_valid_i = 1'b0;
        report_test(0, grp_start);

        for (int i = 0; i < n_rows && !timed_out; i++) begin
            if (i == 0 || row_grp[i] != row_grp[i-1]) begin
                grp_start = err_count;
            end
            issue_row(i, stalls);
            if (!timed_out && row_stall[i] >= 0) begin
                check_flag("stall_o seen", row_stall[i] != 0, stalls > 0);
            end
            if (timed_out || i == n_rows - 1 || row_grp[i+1] != row_grp[i]) begin
                if (!timed_out) begin
                    wait_idle();
                end
                if (!timed_out) begin
                    check_regs();
                end
                report_test(row_grp[i], grp_start);
            end
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, test_fails, check_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
common/alioth_pkg.sv
logic/regfile.sv
issue/issue_unit.sv
muldiv/muldiv_unit.sv
logic/writeback_unit.sv
logic/exec_cluster_top.sv
dv/tb_exec_cluster.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the execute cluster testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f \
    --top-module tb_exec_cluster -o sim_exec_cluster

output=$(./obj_dir/sim_exec_cluster)
echo "$output"

if grep -q "sim passed" <<< "$output"; then
    exit 0
fi
exit 1
